// File: src.f
hdl/mem_pkg.sv
hdl/data_ram.sv
hdl/csr_regs.sv
hdl/mem_access.sv
hdl/mem_subsys_top.sv
tests/mem_subsys_sva.sv
tests/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - hdl/mem_pkg.sv
  - hdl/data_ram.sv
  - hdl/csr_regs.sv
  - hdl/mem_access.sv
  - hdl/mem_subsys_top.sv
  - target: test
    files:
      - tests/mem_subsys_sva.sv
      - tests/mem_subsys_tb.sv

// File: tests/mem_subsys_tb.sv
// testbench for the memory-access subsystem: clock, reset, random stimulus, model and checks
`default_nettype none

module mem_subsys_tb
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ALIGNED   = 150;
    localparam int N_MIS       = 25;
    localparam int N_CSR       = 60;
    localparam int STIM_CYCLES = 2 * N_ALIGNED + 4 * N_MIS + N_CSR + 40;
    localparam int MAX_CYCLES  = 4 * STIM_CYCLES;

    typedef struct packed {
        logic            is_load;
        logic            write_rd;
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] load_data;
        logic            trap;
    } entry_t;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    logic [XLEN-1:0]       alu_result_i;
    logic [XLEN-1:0]       alu_oper2_i;
    mem_oper_t             mem_oper_i;
    logic [CSR_ADDR_W-1:0] csr_waddr_i;
    logic                  csr_we_i;
    logic                  write_rd_i;
    logic [4:0]            rd_addr_i;
    logic                  out_ready_i;
    logic                  out_valid_o;
    logic                  out_is_load_o;
    logic                  out_write_rd_o;
    logic [4:0]            out_rd_addr_o;
    logic [XLEN-1:0]       out_alu_result_o;
    logic [XLEN-1:0]       out_load_data_o;
    logic                  trap_o;
    logic [CSR_ADDR_W-1:0] csr_raddr_i;
    logic [XLEN-1:0]       csr_rdata_o;

    // reference state
    logic [7:0]            ram_m [1024];
    logic [XLEN-1:0]       scratch0_m;
    logic [XLEN-1:0]       scratch1_m;
    logic                  trap_en_m;
    logic [XLEN-1:0]       cnt_m;
    entry_t                exp_q [$];

    int                    errors = 0;
    int                    err_mark = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    cycles = 0;
    bit                    bp_mode = 1'b0;
    logic [CSR_ADDR_W-1:0] csr_sel = CSR_MISALIGN_CTRL;

    mem_oper_t mem_ops [9] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
                               MEM_SB, MEM_SH, MEM_SW, MEM_NOP};
    mem_oper_t mis_ops [5] = '{MEM_LH, MEM_LHU, MEM_LW, MEM_SH, MEM_SW};
    logic [CSR_ADDR_W-1:0] csr_addrs [5] = '{CSR_SCRATCH0, CSR_SCRATCH1,
                                             CSR_MISALIGN_CTRL, CSR_MISALIGN_CNT, 12'h123};

    mem_subsys_top mem_subsys_top_inst (.*);

    always #5 clk_i = ~clk_i;

    function automatic int total_errors();
        return errors + int'(mem_subsys_top_inst.mem_access_inst.mem_subsys_sva_inst.fail_cnt);
    endfunction

    task automatic check_val(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        if (got !== exp)
        begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int op_size(mem_oper_t op);
        if (op inside {MEM_LB, MEM_LBU, MEM_SB})
            return 1;
        if (op inside {MEM_LH, MEM_LHU, MEM_SH})
            return 2;
        return 4;
    endfunction

    function automatic logic [XLEN-1:0] csr_model(logic [CSR_ADDR_W-1:0] a);
        case (a)
            CSR_SCRATCH0:      return scratch0_m;
            CSR_SCRATCH1:      return scratch1_m;
            CSR_MISALIGN_CTRL: return {31'b0, trap_en_m};
            CSR_MISALIGN_CNT:  return cnt_m;
            default:           return '0;
        endcase
    endfunction

    // window 0x100..0x13f with random upper bits, which the RAM ignores
    function automatic logic [XLEN-1:0] rand_addr(int size, bit misalign);
        logic [XLEN-1:0] a;
        a = ($urandom & 32'hFFFF_FC3F) | 32'h0000_0100;
        a = misalign ? a : a & ~(size - 1);
        if (misalign && size == 2)
            a[0] = 1'b1;
        if (misalign && size == 4 && a[1:0] == 2'b00)
            a[1:0] = 2'($urandom_range(1, 3));
        return a;
    endfunction

    // one accepted operation applied to the model
    task automatic model_accept();
        int         size;
        bit         ld;
        bit         st;
        bit         sgn;
        bit         mis;
        bit         trp;
        logic [9:0] ba;
        entry_t     e;
        ld   = mem_oper_i inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        st   = mem_oper_i inside {MEM_SB, MEM_SH, MEM_SW};
        sgn  = mem_oper_i inside {MEM_LB, MEM_LH};
        size = op_size(mem_oper_i);
        mis  = (ld || st) && ((alu_result_i & (size - 1)) != 0);
        trp  = mis && trap_en_m;
        ba   = alu_result_i[9:0] & ~10'(size - 1);
        e    = '0;
        e.is_load  = ld;
        e.write_rd = write_rd_i;
        e.rd       = rd_addr_i;
        e.result   = alu_result_i;
        e.trap     = trp;
        for (int i = 0; i < size; i++)
        begin
            if (ld && !trp)
                e.load_data |= XLEN'(ram_m[ba + i]) << (8 * i);
            if (st && !trp)
                ram_m[ba + i] = alu_oper2_i[8 * i +: 8];
        end
        if (ld && !trp && sgn && e.load_data[8 * size - 1])
            e.load_data |= ~((XLEN'(1) << (8 * size)) - 1);
        if (mis)
            cnt_m++;
        if (csr_we_i && csr_waddr_i == CSR_SCRATCH0)
            scratch0_m = alu_result_i;
        if (csr_we_i && csr_waddr_i == CSR_SCRATCH1)
            scratch1_m = alu_result_i;
        if (csr_we_i && csr_waddr_i == CSR_MISALIGN_CTRL)
            trap_en_m = alu_result_i[0];
        exp_q.push_back(e);
    endtask

    task automatic check_entry(entry_t e);
        check_val("out_is_load_o", out_is_load_o, e.is_load);
        check_val("out_write_rd_o", out_write_rd_o, e.write_rd);
        check_val("out_rd_addr_o", out_rd_addr_o, e.rd);
        check_val("out_alu_result_o", out_alu_result_o, e.result);
        check_val("out_load_data_o", out_load_data_o, e.load_data);
        check_val("trap_o", trap_o, e.trap);
    endtask

    // monitor, all values taken before the edge updates them
    always @(posedge clk_i)
    begin
        if (rstn_i)
        begin
            check_val("csr_rdata_o", csr_rdata_o, csr_model(csr_raddr_i));
            check_val("out_valid_o", out_valid_o, exp_q.size() != 0);
            check_val("in_ready_o", in_ready_o, exp_q.size() == 0 || out_ready_i);
            if (out_valid_o && out_ready_i && exp_q.size() != 0)
                check_entry(exp_q.pop_front());
            if (in_valid_i && in_ready_o)
                model_accept();
        end
    end

    always @(negedge clk_i)
    begin
        out_ready_i = bp_mode ? 1'($urandom) : 1'b1;
        csr_raddr_i = csr_sel;
    end

    always @(posedge clk_i)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic send(mem_oper_t op, logic [XLEN-1:0] addr, logic [XLEN-1:0] data,
                        logic we, logic [CSR_ADDR_W-1:0] waddr);
        @(negedge clk_i);
        in_valid_i   = 1'b1;
        mem_oper_i   = op;
        alu_result_i = addr;
        alu_oper2_i  = data;
        csr_we_i     = we;
        csr_waddr_i  = waddr;
        write_rd_i   = 1'($urandom);
        rd_addr_i    = 5'($urandom);
        @(posedge clk_i);
        while (!in_ready_o)
            @(posedge clk_i);
    endtask

    task automatic idle();
        @(negedge clk_i);
        in_valid_i = 1'b0;
        csr_we_i   = 1'b0;
    endtask

    task automatic finish_test(string name);
        idle();
        while (exp_q.size() != 0)
            @(negedge clk_i);
        tests_run++;
        if (total_errors() != err_mark)
        begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, total_errors() - err_mark);
        end
        else
            $display("test %s: passed", name);
        err_mark = total_errors();
    endtask

    task automatic aligned_run(bit gaps);
        mem_oper_t op;
        for (int n = 0; n < N_ALIGNED; n++)
        begin
            op = mem_ops[$urandom % 9];
            if (gaps && $urandom % 4 == 0)
                idle();
            send(op, rand_addr(op_size(op), 1'b0), $urandom, 1'b0, CSR_SCRATCH0);
        end
    endtask

    // each misaligned access is followed by a word load of the same word
    task automatic misaligned_run();
        mem_oper_t       op;
        logic [XLEN-1:0] addr;
        csr_sel = CSR_MISALIGN_CNT;
        for (int n = 0; n < N_MIS; n++)
        begin
            op   = mis_ops[$urandom % 5];
            addr = rand_addr(op_size(op), 1'b1);
            send(op, addr, $urandom, 1'b0, CSR_SCRATCH0);
            send(MEM_LW, addr & ~32'h3, $urandom, 1'b0, CSR_SCRATCH0);
        end
    endtask

    initial
    begin
        mem_oper_t op;
        void'($urandom(32'h4f465b45));
        rstn_i       = 1'b0;
        in_valid_i   = 1'b0;
        alu_result_i = '0;
        alu_oper2_i  = '0;
        mem_oper_i   = MEM_NOP;
        csr_waddr_i  = '0;
        csr_we_i     = 1'b0;
        write_rd_i   = 1'b0;
        rd_addr_i    = '0;
        out_ready_i  = 1'b1;
        csr_raddr_i  = CSR_MISALIGN_CTRL;
        for (int i = 0; i < 1024; i++)
            ram_m[i] = '0;
        scratch0_m = '0;
        scratch1_m = '0;
        trap_en_m  = 1'b1;
        cnt_m      = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        check_val("out_valid_o", out_valid_o, 32'h0);
        check_val("trap_o", trap_o, 32'h0);
        check_val("out_write_rd_o", out_write_rd_o, 32'h0);
        check_val("in_ready_o", in_ready_o, 32'h1);
        repeat (2) @(posedge clk_i);
        check_val("csr_rdata_o", csr_rdata_o, 32'h1);
        csr_sel = CSR_MISALIGN_CNT;
        repeat (2) @(posedge clk_i);
        check_val("csr_rdata_o", csr_rdata_o, 32'h0);
        finish_test("reset values");

        aligned_run(1'b0);
        finish_test("aligned loads and stores");

        bp_mode = 1'b1;
        aligned_run(1'b1);
        finish_test("back-pressure");
        bp_mode = 1'b0;

        misaligned_run();
        finish_test("misaligned with trap");

        // trap off, accesses are aligned down
        send(MEM_NOP, 32'h0, 32'h0, 1'b1, CSR_MISALIGN_CTRL);
        misaligned_run();
        finish_test("misaligned without trap");

        for (int n = 0; n < N_CSR; n++)
        begin
            csr_sel = csr_addrs[$urandom % 5];
            op      = ($urandom % 2) ? MEM_NOP : mem_ops[$urandom % 9];
            send(op, (op == MEM_NOP) ? $urandom : rand_addr(op_size(op), 1'b0),
                 $urandom, 1'b1, csr_addrs[$urandom % 5]);
        end
        finish_test("csr writes");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule : mem_subsys_tb

`default_nettype wire

// File: tests/mem_subsys_sva.sv
// assertions on the MEM/WB handshake and the store byte lanes, bound into mem_access
`default_nettype none

module mem_subsys_sva
    import mem_pkg::*;
(
    input wire logic            clk_i,
    input wire logic            rstn_i,
    input wire logic            in_ready_o,
    input wire logic            out_ready_i,
    input wire logic            out_valid_o,
    input wire logic [3:0]      wsel_byte_o,
    input wire mem_oper_t       mem_oper_i,
    input wire logic [XLEN-1:0] out_alu_result_o,
    input wire logic [XLEN-1:0] out_load_data_o,
    input wire logic [4:0]      out_rd_addr_o,
    input wire logic            out_is_load_o,
    input wire logic            out_write_rd_o,
    input wire logic            trap_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // a stalled entry keeps its valid and payload
    held_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_alu_result_o,
        out_load_data_o, out_rd_addr_o, out_is_load_o, out_write_rd_o, trap_o}))
    else
    begin
        $error("MEM/WB entry changed or dropped while stalled");
        fail_cnt++;
    end

    // no RAM write while the stage is blocked
    quiet_when_stalled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !in_ready_o |-> wsel_byte_o == 4'b0000)
    else
    begin
        $error("byte lanes enabled while in_ready_o is low");
        fail_cnt++;
    end

    // partial lane patterns belong to byte and half stores
    lanes_partial: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ($countones(wsel_byte_o) inside {1, 2}) |-> (mem_oper_i inside {MEM_SB, MEM_SH}))
    else
    begin
        $error("partial byte lanes for an operation that is no byte or half store");
        fail_cnt++;
    end

endmodule : mem_subsys_sva

bind mem_access mem_subsys_sva mem_subsys_sva_inst (.*);

`default_nettype wire

// File: hdl/mem_subsys_top.sv
// memory-access subsystem joining the load/store stage, data RAM and CSR block
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // execute side
    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic [XLEN-1:0]       alu_oper2_i,
    input  wire mem_oper_t             mem_oper_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic                  csr_we_i,
    input  wire logic                  write_rd_i,
    input  wire logic [4:0]            rd_addr_i,

    // writeback side
    input  wire logic                  out_ready_i,
    output logic                       out_valid_o,
    output logic                       out_is_load_o,
    output logic                       out_write_rd_o,
    output logic      [4:0]            out_rd_addr_o,
    output logic      [XLEN-1:0]       out_alu_result_o,
    output logic      [XLEN-1:0]       out_load_data_o,
    output logic                       trap_o,

    // CSR read port
    input  wire logic [CSR_ADDR_W-1:0] csr_raddr_i,
    output logic      [XLEN-1:0]       csr_rdata_o
);

    // stage <-> RAM
    logic [DMEM_AW-1:0]    ram_addr;
    logic [3:0]            wsel_byte;
    logic [XLEN-1:0]       ram_wdata;
    logic [XLEN-1:0]       ram_rdata;

    // stage <-> CSR block
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;
    logic                  csr_we;
    logic                  misalign;
    logic                  trap_en;

    mem_access mem_access_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .alu_result_i     (alu_result_i),
        .alu_oper2_i      (alu_oper2_i),
        .mem_oper_i       (mem_oper_i),
        .csr_waddr_i      (csr_waddr_i),
        .csr_we_i         (csr_we_i),
        .write_rd_i       (write_rd_i),
        .rd_addr_i        (rd_addr_i),
        .ram_addr_o       (ram_addr),
        .wsel_byte_o      (wsel_byte),
        .wdata_o          (ram_wdata),
        .rdata_i          (ram_rdata),
        .csr_waddr_o      (csr_waddr),
        .csr_wdata_o      (csr_wdata),
        .csr_we_o         (csr_we),
        .misalign_o       (misalign),
        .trap_en_i        (trap_en),
        .out_ready_i      (out_ready_i),
        .out_valid_o      (out_valid_o),
        .out_is_load_o    (out_is_load_o),
        .out_write_rd_o   (out_write_rd_o),
        .out_rd_addr_o    (out_rd_addr_o),
        .out_alu_result_o (out_alu_result_o),
        .out_load_data_o  (out_load_data_o),
        .trap_o           (trap_o)
    );

    data_ram data_ram_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .addr_i      (ram_addr),
        .wsel_byte_i (wsel_byte),
        .wdata_i     (ram_wdata),
        .rdata_o     (ram_rdata)
    );

    csr_regs csr_regs_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .we_i       (csr_we),
        .waddr_i    (csr_waddr),
        .wdata_i    (csr_wdata),
        .misalign_i (misalign),
        .raddr_i    (csr_raddr_i),
        .rdata_o    (csr_rdata_o),
        .trap_en_o  (trap_en)
    );

endmodule : mem_subsys_top

`default_nettype wire

// File: hdl/mem_access.sv
// load/store stage with lane steering, load extension, alignment check and MEM/WB register
`default_nettype none

module mem_access
    import mem_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // from execute
    input  wire logic                  in_valid_i,
    output logic                       in_ready_o,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic [XLEN-1:0]       alu_oper2_i,
    input  wire mem_oper_t             mem_oper_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic                  csr_we_i,
    input  wire logic                  write_rd_i,
    input  wire logic [4:0]            rd_addr_i,

    // data RAM
    output logic      [DMEM_AW-1:0]    ram_addr_o,
    output logic      [3:0]            wsel_byte_o,
    output logic      [XLEN-1:0]       wdata_o,
    input  wire logic [XLEN-1:0]       rdata_i,

    // CSR block
    output logic      [CSR_ADDR_W-1:0] csr_waddr_o,
    output logic      [XLEN-1:0]       csr_wdata_o,
    output logic                       csr_we_o,
    output logic                       misalign_o,
    input  wire logic                  trap_en_i,

    // MEM/WB register towards writeback
    input  wire logic                  out_ready_i,
    output logic                       out_valid_o,
    output logic                       out_is_load_o,
    output logic                       out_write_rd_o,
    output logic      [4:0]            out_rd_addr_o,
    output logic      [XLEN-1:0]       out_alu_result_o,
    output logic      [XLEN-1:0]       out_load_data_o,
    output logic                       trap_o
);

    mem_oper_u       op;
    logic            op_known;
    logic            is_load;
    logic            is_store;
    logic            misaligned;
    logic            trap;
    logic            accept;
    logic [1:0]      offset;
    logic [3:0]      lanes;
    logic [XLEN-1:0] shifted_rdata;
    logic [XLEN-1:0] load_data;

    assign op.oper = mem_oper_i;

    // unlisted codes fall back to a NOP
    always_comb
    begin
        case (op.oper)
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
            MEM_SB, MEM_SH, MEM_SW: op_known = 1'b1;
            default:                op_known = 1'b0;
        endcase
    end

    assign is_store = op_known && op.f.is_store;
    assign is_load  = op_known && !op.f.is_store && (op.f.size != SIZE_NONE);

    assign misaligned = (is_load || is_store) &&
                        (((op.f.size == SIZE_HALF) && alu_result_i[0]) ||
                         ((op.f.size == SIZE_WORD) && (alu_result_i[1:0] != 2'b00)));
    assign trap = misaligned && trap_en_i;

    // byte offset within the word, forced down to the access size
    always_comb
    begin
        case (op.f.size)
            SIZE_BYTE: offset = alu_result_i[1:0];
            SIZE_HALF: offset = {alu_result_i[1], 1'b0};
            default:   offset = 2'b00;
        endcase
    end

    // handshake, the register frees up in the same edge it drains
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    // store lanes before shifting into position
    always_comb
    begin
        case (op.f.size)
            SIZE_BYTE: lanes = 4'b0001;
            SIZE_HALF: lanes = 4'b0011;
            default:   lanes = 4'b1111;
        endcase
    end

    assign ram_addr_o  = alu_result_i[DMEM_AW+1:2];
    assign wdata_o     = alu_oper2_i << {offset, 3'b000};
    assign wsel_byte_o = (accept && is_store && !trap) ? (lanes << offset) : 4'b0000;

    // load lane select and extension
    assign shifted_rdata = rdata_i >> {offset, 3'b000};

    always_comb
    begin
        load_data = '0;
        if (is_load && !trap)
        begin
            case (op.f.size)
                SIZE_BYTE:
                begin
                    load_data = op.f.is_unsigned ? XLEN'(shifted_rdata[7:0])
                                                 : XLEN'(signed'(shifted_rdata[7:0]));
                end
                SIZE_HALF:
                begin
                    load_data = op.f.is_unsigned ? XLEN'(shifted_rdata[15:0])
                                                 : XLEN'(signed'(shifted_rdata[15:0]));
                end
                default: load_data = shifted_rdata;
            endcase
        end
    end

    // CSR write goes through even when the access traps
    assign csr_waddr_o = csr_waddr_i;
    assign csr_wdata_o = alu_result_i;
    assign csr_we_o    = accept && csr_we_i;
    assign misalign_o  = accept && misaligned;

    // MEM/WB control bits
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            out_valid_o    <= 1'b0;
            out_is_load_o  <= 1'b0;
            out_write_rd_o <= 1'b0;
            trap_o         <= 1'b0;
        end
        else if (accept)
        begin
            out_valid_o    <= 1'b1;
            out_is_load_o  <= is_load;
            out_write_rd_o <= write_rd_i;
            trap_o         <= trap;
        end
        else if (out_ready_i)
        begin
            out_valid_o <= 1'b0;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk_i)
    begin
        if (accept)
        begin
            out_rd_addr_o    <= rd_addr_i;
            out_alu_result_o <= alu_result_i;
            out_load_data_o  <= load_data;
        end
    end

endmodule : mem_access

`default_nettype wire

// File: hdl/csr_regs.sv
// CSR block with scratch registers, misalignment trap control and misalignment counter
`default_nettype none

module csr_regs
    import mem_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  we_i,
    input  wire logic [CSR_ADDR_W-1:0] waddr_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic                  misalign_i,
    input  wire logic [CSR_ADDR_W-1:0] raddr_i,
    output logic      [XLEN-1:0]       rdata_o,
    output logic                       trap_en_o
);

    logic [XLEN-1:0] scratch0;
    logic [XLEN-1:0] scratch1;
    logic            trap_en;
    logic [XLEN-1:0] misalign_cnt;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            scratch0 <= '0;
            scratch1 <= '0;
            // trap is on out of reset
            trap_en  <= 1'b1;
        end
        else if (we_i)
        begin
            // counter and unmapped addresses are not writable
            case (waddr_i)
                CSR_SCRATCH0:      scratch0 <= wdata_i;
                CSR_SCRATCH1:      scratch1 <= wdata_i;
                CSR_MISALIGN_CTRL: trap_en  <= wdata_i[0];
                default:
                begin
                end
            endcase
        end
    end

    // wraps on overflow
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            misalign_cnt <= '0;
        end
        else if (misalign_i)
        begin
            misalign_cnt <= misalign_cnt + 1'b1;
        end
    end

    always_comb
    begin
        case (raddr_i)
            CSR_SCRATCH0:      rdata_o = scratch0;
            CSR_SCRATCH1:      rdata_o = scratch1;
            CSR_MISALIGN_CTRL: rdata_o = {{(XLEN-1){1'b0}}, trap_en};
            CSR_MISALIGN_CNT:  rdata_o = misalign_cnt;
            default:           rdata_o = '0;
        endcase
    end

    assign trap_en_o = trap_en;

endmodule : csr_regs

`default_nettype wire

// File: hdl/data_ram.sv
// word-organised data RAM with combinational read and byte-enabled write
`default_nettype none

module data_ram
    import mem_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rstn_i,
    input  wire logic [DMEM_AW-1:0] addr_i,
    input  wire logic [3:0]         wsel_byte_i,
    input  wire logic [XLEN-1:0]    wdata_i,
    output logic      [XLEN-1:0]    rdata_o
);

    logic [XLEN-1:0] mem [DMEM_WORDS];

    // read path has no latency, loads see the word in the same cycle
    assign rdata_o = mem[addr_i];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int w = 0; w < DMEM_WORDS; w++)
            begin
                mem[w] <= '0;
            end
        end
        else
        begin
            // one enable per byte lane
            for (int b = 0; b < 4; b++)
            begin
                if (wsel_byte_i[b])
                begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule : data_ram

`default_nettype wire

// File: hdl/mem_pkg.sv
// shared widths, CSR addresses, RAM depth and load/store operation types
`default_nettype none

package mem_pkg;

    // datapath and CSR widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // data RAM geometry, word index taken from address bits 9..2
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // CSR map
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH0      = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH1      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISALIGN_CTRL = 12'h7C0;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISALIGN_CNT  = 12'h7C1;

    // access size field of an operation code
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;
    localparam logic [1:0] SIZE_NONE = 2'b11;

    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_NOP = 4'b0011,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_oper_t;

    // same code seen as a named operation or as its bit fields
    typedef union packed {
        mem_oper_t oper;
        struct packed {
            logic       is_store;
            logic       is_unsigned;
            logic [1:0] size;
        } f;
    } mem_oper_u;

endpackage : mem_pkg

`default_nettype wire
